// ==== rtl/spi_cfg.svh ====
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// bits per SPI frame, one byte on the wire
`define SPI_FRAME_BITS 8

// width of the divider select field in the configuration byte
// half period of sclk is 2^div_sel cycles of CLK
`define SPI_DIV_BITS 3

// bit counters must reach SPI_FRAME_BITS itself, so one bit wider than the index
`define SPI_CNT_BITS 4

`endif

// ==== rtl/spi_frame_pkg.sv ====
`include "spi_cfg.svh"

package spi_frame_pkg;

    typedef logic [`SPI_FRAME_BITS-1:0] spi_byte_t; // one data frame as seen by the host

    // configuration byte split into its fields, msb first
    typedef struct packed {
        logic                                     enable;    // 0 blocks every transfer
        logic                                     lsb_first; // 1 sends and receives bit 0 first
        logic [`SPI_FRAME_BITS-3-`SPI_DIV_BITS:0] reserved;  // kept for later use
        logic [`SPI_DIV_BITS-1:0]                 div_sel;   // sclk half period select
    } spi_cfg_fields_t;

    // the host writes the raw byte, the sequencer and the divider read the fields
    typedef union packed {
        spi_byte_t       raw;
        spi_cfg_fields_t fields;
    } spi_cfg_u;

endpackage

// ==== rtl/spi_ctrl_pkg.sv ====
package spi_ctrl_pkg;

    // transfer sequencer states
    // idle waits for a write, load gives the slave a setup cycle with cs_n low,
    // shift runs sclk until the last bit has gone, finish is the deselect cycle
    typedef enum logic [1:0] {
        xfer_idle   = 2'd0,
        xfer_load   = 2'd1,
        xfer_shift  = 2'd2,
        xfer_finish = 2'd3
    } spi_xfer_state_e;

endpackage

// ==== rtl/spi_shift_tx.sv ====
`include "spi_cfg.svh"

module spi_shift_tx
    import spi_frame_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      load_pulse, // parallel load strobe from the sequencer
    input  spi_byte_t wdata,
    input  logic      fall_pulse, // shift strobe, one per falling sclk edge
    input  logic      lsb_first,
    output logic      mosi,
    output logic      tx_empty
);
    // count value once the frame is out
    localparam logic [`SPI_CNT_BITS-1:0] all_sent = `SPI_FRAME_BITS;

    spi_byte_t                shift_q;  // outgoing bits, the next one sits at the selected end
    logic [`SPI_CNT_BITS-1:0] sent_cnt; // bits already shifted out
    logic                     shift_en;

    assign shift_en = fall_pulse && !tx_empty; // no shifting past the end of the frame
    assign tx_empty = (sent_cnt == all_sent);

    // the current bit is on the line from the load until the next falling edge
    assign mosi = tx_empty ? 1'b0 : (lsb_first ? shift_q[0] : shift_q[`SPI_FRAME_BITS-1]);

    // sent counter starts full so that tx_empty is high out of reset
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            sent_cnt <= all_sent;
        end else if (load_pulse) begin
            sent_cnt <= '0; // a fresh byte, nothing sent yet
        end else if (shift_en) begin
            sent_cnt <= sent_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (load_pulse) begin
            shift_q <= wdata;
        end else if (shift_en) begin
            if (lsb_first) begin
                shift_q <= {1'b0, shift_q[`SPI_FRAME_BITS-1:1]}; // bit 1 moves down to the line
            end else begin
                shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], 1'b0}; // next lower bit moves up
            end
        end
    end

endmodule

// ==== rtl/spi_shift_rx.sv ====
`include "spi_cfg.svh"

module spi_shift_rx
    import spi_frame_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      rise_pulse, // sample strobe, one per rising sclk edge
    input  logic      miso,
    input  logic      lsb_first,
    input  logic      active,     // high while sclk is running
    input  logic      read,       // host read strobe, clears the flags
    output spi_byte_t rdata,
    output logic      rx_full,
    output logic      rx_overrun
);
    localparam logic [`SPI_CNT_BITS-1:0] last_bit = `SPI_FRAME_BITS - 1;

    spi_byte_t                shift_q;    // bits collected so far
    spi_byte_t                hold_q;     // last complete byte, shown to the host
    logic [`SPI_CNT_BITS-1:0] recv_cnt;   // bits sampled in this frame
    logic                     frame_done; // all bits in, waiting for sclk to stop
    logic                     sample;
    logic                     commit;

    assign sample = active && rise_pulse && !frame_done;
    // the byte is handed over when the sequencer stops sclk, the same cycle busy falls
    assign commit = frame_done && !active;
    assign rdata  = hold_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            recv_cnt   <= '0;
            frame_done <= 1'b0;
        end else if (commit) begin
            recv_cnt   <= '0; // ready for the next frame
            frame_done <= 1'b0;
        end else if (sample) begin
            recv_cnt <= recv_cnt + 1'b1;
            if (recv_cnt == last_bit) begin
                frame_done <= 1'b1; // eighth rising edge
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (sample) begin
            if (lsb_first) begin
                shift_q <= {miso, shift_q[`SPI_FRAME_BITS-1:1]}; // first bit ends up in bit 0
            end else begin
                shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], miso}; // first bit ends up in the msb
            end
        end
        if (commit) begin
            hold_q <= shift_q;
        end
    end

    // a new byte wins over a read in the same cycle
    // the read then counts for the old byte, so no overrun
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rx_full    <= 1'b0;
            rx_overrun <= 1'b0;
        end else if (commit) begin
            rx_full    <= 1'b1;
            rx_overrun <= (rx_full && !read) || (rx_overrun && !read); // old byte never read
        end else if (read) begin
            rx_full    <= 1'b0;
            rx_overrun <= 1'b0;
        end
    end

endmodule

// ==== rtl/spi_sclk_gen.sv ====
`include "spi_cfg.svh"

module spi_sclk_gen (
    input  logic                     CLK,
    input  logic                     rst_n,
    input  logic                     run,        // level from the sequencer
    input  logic [`SPI_DIV_BITS-1:0] div_sel,
    output logic                     sclk,
    output logic                     rise_pulse, // sclk goes high at the end of this cycle
    output logic                     fall_pulse  // sclk goes low at the end of this cycle
);
    // wide enough for the longest half period, 2^(2^SPI_DIV_BITS - 1) cycles
    localparam int cnt_w = (1 << `SPI_DIV_BITS) - 1;

    logic [cnt_w-1:0] half_cnt;  // cycles spent in the current sclk phase
    logic [cnt_w-1:0] half_last; // terminal count of a phase
    logic             toggle;

    // for the widest select the shifted one falls off the top and the
    // subtraction wraps to all ones, which is still the right terminal count
    assign half_last = (cnt_w'(1) << div_sel) - cnt_w'(1);

    assign toggle     = run && (half_cnt == half_last);
    assign rise_pulse = toggle && !sclk; // both shift blocks act on the same edge as sclk
    assign fall_pulse = toggle && sclk;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
            sclk     <= 1'b0;
        end else if (!run) begin
            half_cnt <= '0; // idle low, and the next frame starts with a full low phase
            sclk     <= 1'b0;
        end else if (toggle) begin
            half_cnt <= '0;
            sclk     <= !sclk;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/spi_xfer_ctrl.sv ====
`include "spi_cfg.svh"

module spi_xfer_ctrl
    import spi_frame_pkg::*;
    import spi_ctrl_pkg::*;
(
    input  logic                     CLK,
    input  logic                     rst_n,
    input  logic                     cfg_write,  // stores cfg_data
    input  spi_byte_t                cfg_data,
    input  logic                     write,      // starts a transfer when not busy
    input  logic                     tx_empty,   // last bit has left the transmitter
    output logic                     load_pulse, // transmitter takes wdata
    output logic                     run,        // sclk enable
    output logic                     cs_n,
    output logic                     busy,
    output logic                     lsb_first,
    output logic [`SPI_DIV_BITS-1:0] div_sel
);
    spi_cfg_u        cfg_q;            // configuration byte, zero means disabled
    spi_xfer_state_e state_q, state_d;
    logic            start;

    // cs_n is asserted only while the frame is set up and shifted
    assign busy = (state_q == xfer_load) || (state_q == xfer_shift);
    assign cs_n = !busy;

    // a write while busy or disabled is dropped, there is no queue
    assign start      = write && cfg_q.fields.enable && !busy;
    assign load_pulse = start; // wdata is only valid during the strobe

    // tx_empty rises on the edge of the last falling sclk, so sclk stops right there
    assign run = (state_q == xfer_shift) && !tx_empty;

    assign lsb_first = cfg_q.fields.lsb_first;
    assign div_sel   = cfg_q.fields.div_sel;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q.raw <= '0;
        end else if (cfg_write) begin
            cfg_q.raw <= cfg_data; // the host sees the register as one byte
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            xfer_idle: begin
                if (start) state_d = xfer_load;
            end
            xfer_load: begin
                state_d = xfer_shift; // one setup cycle before the first sclk phase
            end
            xfer_shift: begin
                if (tx_empty) state_d = xfer_finish;
            end
            xfer_finish: begin
                state_d = start ? xfer_load : xfer_idle; // back to back frames allowed here
            end
            default: begin
                state_d = xfer_idle;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= xfer_idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== rtl/spi_master.sv ====
`include "spi_cfg.svh"

module spi_master
    import spi_frame_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      cfg_write,
    input  spi_byte_t cfg_data,
    input  logic      write,
    input  spi_byte_t wdata,
    input  logic      read,
    input  logic      miso,
    output spi_byte_t rdata,
    output logic      busy,
    output logic      tx_empty,
    output logic      rx_full,
    output logic      rx_overrun,
    output logic      sclk,
    output logic      mosi,
    output logic      cs_n
);
    logic                     load_pulse;
    logic                     run;        // sclk runs and the receiver samples while high
    logic                     rise_pulse;
    logic                     fall_pulse;
    logic                     lsb_first;
    logic [`SPI_DIV_BITS-1:0] div_sel;

    spi_xfer_ctrl spi_xfer_ctrl_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .cfg_write  (cfg_write),
        .cfg_data   (cfg_data),
        .write      (write),
        .tx_empty   (tx_empty),
        .load_pulse (load_pulse),
        .run        (run),
        .cs_n       (cs_n),
        .busy       (busy),
        .lsb_first  (lsb_first),
        .div_sel    (div_sel)
    );

    spi_sclk_gen spi_sclk_gen_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .run        (run),
        .div_sel    (div_sel),
        .sclk       (sclk),
        .rise_pulse (rise_pulse),
        .fall_pulse (fall_pulse)
    );

    spi_shift_tx spi_shift_tx_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .load_pulse (load_pulse),
        .wdata      (wdata),
        .fall_pulse (fall_pulse),
        .lsb_first  (lsb_first),
        .mosi       (mosi),
        .tx_empty   (tx_empty)
    );

    spi_shift_rx spi_shift_rx_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .rise_pulse (rise_pulse),
        .miso       (miso),
        .lsb_first  (lsb_first),
        .active     (run),
        .read       (read),
        .rdata      (rdata),
        .rx_full    (rx_full),
        .rx_overrun (rx_overrun)
    );

endmodule

// ==== bench/spi_master_props.sv ====
module spi_master_props (
    input logic CLK,
    input logic rst_n,
    input logic busy,
    input logic cs_n,
    input logic sclk,
    input logic rx_full,
    input logic rx_overrun
);
    timeunit 1ns;
    timeprecision 100ps;

    // the received byte is flagged in the very cycle the frame ends and busy drops
    byte_flagged_at_end: assert property (@(posedge CLK) disable iff (!rst_n)
        $fell(busy) |-> rx_full)
        else $error("busy fell without rx_full being set in the same cycle");

    // sclk idles low between frames, mode 0
    sclk_idle_low: assert property (@(posedge CLK) disable iff (!rst_n)
        cs_n |-> !sclk)
        else $error("sclk is high while cs_n is high");

    // an overrun always leaves a byte waiting in the holding register
    overrun_needs_full: assert property (@(posedge CLK) disable iff (!rst_n)
        rx_overrun |-> rx_full)
        else $error("rx_overrun is set while rx_full is low");

endmodule

// ==== bench/spi_master_tb.sv ====
`include "spi_cfg.svh"

module spi_master_tb
    import spi_frame_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period     = 20;
    localparam int drive_skew     = 2;    // inputs change this long after the rising edge
    localparam int timeout_cycles = 5000;

    logic      CLK = 1'b0;
    logic      rst_n;
    logic      cfg_write;
    spi_byte_t cfg_data;
    logic      write;
    spi_byte_t wdata;
    logic      read;
    logic      miso;
    spi_byte_t rdata;
    logic      busy;
    logic      tx_empty;
    logic      rx_full;
    logic      rx_overrun;
    logic      sclk;
    logic      mosi;
    logic      cs_n;

    int        seed = 32'h39b5_8f85;
    logic      cur_lsb = 1'b0;   // bit order the slave uses, follows the last configuration
    spi_byte_t slave_got = '0;   // byte the slave assembled in its last frame
    logic      sent_any = 1'b0;  // at least one frame has gone out
    spi_byte_t last_sent = '0;
    spi_byte_t exp_sent_q[$];    // what the slave should have received, one entry per frame
    spi_byte_t exp_rdata_q[$];   // what the host should read, same order
    int        checked = 0;      // entries already compared
    int        cycle_no = 0;
    int        last_rise = 0;
    int        rise_gap = 0;     // CLK cycles between the two latest rising sclk edges
    logic      sclk_prev = 1'b0;

    always #(clk_period / 2) CLK = !CLK;

    spi_master spi_master_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .cfg_write  (cfg_write),
        .cfg_data   (cfg_data),
        .write      (write),
        .wdata      (wdata),
        .read       (read),
        .miso       (miso),
        .rdata      (rdata),
        .busy       (busy),
        .tx_empty   (tx_empty),
        .rx_full    (rx_full),
        .rx_overrun (rx_overrun),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n)
    );

    bind spi_master spi_master_props spi_master_props_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .busy       (busy),
        .cs_n       (cs_n),
        .sclk       (sclk),
        .rx_full    (rx_full),
        .rx_overrun (rx_overrun)
    );

    // the slave answers with the inverse of the frame before, and A5 to the very first one
    function automatic spi_byte_t expect_rx(input logic have_prev, input spi_byte_t prev_sent);
        if (have_prev) begin
            return ~prev_sent;
        end else begin
            return 8'hA5;
        end
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input spi_byte_t actual,
                               input spi_byte_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < timeout_cycles) begin
            @(negedge CLK);
            n++;
        end
        if (busy !== level) begin
            $display("Timeout at %0t ns: busy did not reach %b within %0d cycles",
                     $time, level, timeout_cycles);
            abort_run();
        end
    endtask

    // the compare process takes one entry per falling CLK edge
    task automatic wait_compare();
        int n;
        n = 0;
        while (checked < exp_sent_q.size() && n < timeout_cycles) begin
            @(negedge CLK);
            n++;
        end
        if (checked < exp_sent_q.size()) begin
            $display("Timeout at %0t ns: the compare process never checked the last frame",
                     $time);
            abort_run();
        end
    endtask

    task automatic host_config(input logic en, input logic lsb,
                               input logic [`SPI_DIV_BITS-1:0] div);
        @(posedge CLK);
        #drive_skew;
        cfg_data  = {en, lsb, 3'b000, div}; // enable, order, reserved, divider from the top
        cfg_write = 1'b1;
        cur_lsb   = lsb;
        @(posedge CLK);
        #drive_skew cfg_write = 1'b0;
    endtask

    task automatic start_write(input spi_byte_t data);
        @(posedge CLK);
        #drive_skew;
        wdata = data;
        write = 1'b1;
        @(posedge CLK);
        #drive_skew write = 1'b0;
    endtask

    task automatic host_read();
        @(posedge CLK);
        #drive_skew read = 1'b1;
        @(posedge CLK);
        #drive_skew read = 1'b0;
    endtask

    // one whole frame, the results go to the compare process
    task automatic run_transfer(input spi_byte_t data);
        start_write(data);
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_value("rx_full", 8'(rx_full), 8'h01); // raised with the fall of busy
        exp_sent_q.push_back(data);
        exp_rdata_q.push_back(expect_rx(sent_any, last_sent));
        sent_any  = 1'b1;
        last_sent = data;
        wait_compare();
    endtask

    // mode 0 slave, first bit ready when cs_n falls, next bit after each falling sclk
    initial begin : slave_model
        spi_byte_t reply;
        spi_byte_t shift_in;
        spi_byte_t shift_out;
        reply = 8'hA5;
        miso  = 1'b0;
        forever begin
            @(negedge cs_n);
            shift_out = reply;
            shift_in  = '0;
            for (int i = 0; i < `SPI_FRAME_BITS; i++) begin
                #drive_skew;
                miso = cur_lsb ? shift_out[0] : shift_out[`SPI_FRAME_BITS-1];
                @(posedge sclk); // mosi only moves on falling edges, so it is steady here
                if (cur_lsb) begin
                    shift_in = {mosi, shift_in[`SPI_FRAME_BITS-1:1]};
                end else begin
                    shift_in = {shift_in[`SPI_FRAME_BITS-2:0], mosi};
                end
                if (i < `SPI_FRAME_BITS - 1) begin
                    @(negedge sclk);
                    shift_out = cur_lsb ? shift_out >> 1 : shift_out << 1;
                end
            end
            @(posedge cs_n);
            slave_got = shift_in;
            reply     = ~shift_in;
        end
    end

    // sclk period monitor, sampled mid cycle where sclk is settled
    always @(negedge CLK) begin
        cycle_no++;
        if (sclk && !sclk_prev) begin
            rise_gap  = cycle_no - last_rise;
            last_rise = cycle_no;
        end
        sclk_prev = sclk;
    end

    always @(negedge CLK) begin : compare
        if (checked < exp_sent_q.size()) begin
            check_value("slave rx byte", slave_got, exp_sent_q[checked]);
            check_value("rdata", rdata, exp_rdata_q[checked]);
            checked++;
        end
    end

    initial begin : stimulus
        int rnd;
        rst_n     = 1'b0;
        cfg_write = 1'b0;
        cfg_data  = '0;
        write     = 1'b0;
        wdata     = '0;
        read      = 1'b0;
        repeat (10) @(posedge CLK);
        #drive_skew rst_n = 1'b1;

        // idle state out of reset
        @(negedge CLK);
        check_value("busy", 8'(busy), 8'h00);
        check_value("rx_full", 8'(rx_full), 8'h00);
        check_value("rx_overrun", 8'(rx_overrun), 8'h00);
        check_value("cs_n", 8'(cs_n), 8'h01);
        check_value("sclk", 8'(sclk), 8'h00);
        check_value("tx_empty", 8'(tx_empty), 8'h01);
        start_write(8'h55); // enable is still zero, the strobe has to be dropped
        repeat (20) begin
            @(negedge CLK);
            check_value("busy", 8'(busy), 8'h00);
            check_value("cs_n", 8'(cs_n), 8'h01);
        end

        // msb first at full speed
        host_config(1'b1, 1'b0, 3'd0);
        run_transfer(8'h3C);
        check_value("rdata", rdata, 8'hA5);
        host_read();

        // lsb first, the slave assembles in the same order
        host_config(1'b1, 1'b1, 3'd0);
        run_transfer(8'hC1);
        host_read();
        // the reply to this one is 3E, whose bit order matters on the way in
        run_transfer(8'h2D);
        host_read();

        for (int d = 0; d < 3; d++) begin
            host_config(1'b1, 1'b0, 3'(d));
            run_transfer(8'h5A + 8'(d));
            check_value("sclk rise gap", 8'(rise_gap), 8'(2 << d)); // two half periods
            host_read();
        end

        // overrun when the first byte is never read
        host_config(1'b1, 1'b0, 3'd1);
        run_transfer(8'h81);
        check_value("rx_overrun", 8'(rx_overrun), 8'h00);
        run_transfer(8'h7E);
        check_value("rx_overrun", 8'(rx_overrun), 8'h01);
        host_read();
        @(negedge CLK);
        check_value("rx_full", 8'(rx_full), 8'h00);
        check_value("rx_overrun", 8'(rx_overrun), 8'h00);

        // random data with random bit order and divider
        for (int k = 0; k < 20; k++) begin
            rnd = $random(seed);
            host_config(1'b1, rnd[8], {2'b00, rnd[9]});
            run_transfer(rnd[7:0]);
            host_read();
            @(negedge CLK);
            check_value("rx_full", 8'(rx_full), 8'h00);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/spi_frame_pkg.sv
rtl/spi_ctrl_pkg.sv
rtl/spi_shift_tx.sv
rtl/spi_shift_rx.sv
rtl/spi_sclk_gen.sv
rtl/spi_xfer_ctrl.sv
rtl/spi_master.sv
bench/spi_master_props.sv
bench/spi_master_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the SPI master testbench with Verilator and runs it
# the exit status of the model tells pass from fail
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module spi_master_tb -o spi_master_sim
./obj_dir/spi_master_sim
